/* common/fmap_settings.svh */
`ifndef FMAP_SETTINGS_SVH
`define FMAP_SETTINGS_SVH

// Pixel and map geometry
`define FMAP_DATA_WIDTH 32
`define FMAP_IFM_SIZE 8
`define FMAP_ADDR_W 6

// Two groups of banks, one bank per unit in each
`define FMAP_UNITS 3
`define FMAP_GROUPS 2

// APB side
`define FMAP_APB_ADDR_W 12
`define FMAP_CTRL_BIT 11 // Set in PADDR selects CTRL

`endif

/* common/fmap_pkg.sv */
`default_nettype none

`include "fmap_settings.svh"

package fmap_pkg;

	// One feature-map pixel
	typedef logic [`FMAP_DATA_WIDTH-1:0] pixel_t;

	// Pixel index inside one map
	typedef logic [`FMAP_ADDR_W-1:0] pix_addr_t;

	// Unit number, code 3 is out of range
	typedef logic [$clog2(`FMAP_UNITS)-1:0] unit_idx_t;

	// Ping-pong group number
	typedef logic [$clog2(`FMAP_GROUPS)-1:0] group_t;

endpackage

`default_nettype wire

/* common/fmap_access_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fmap_access_if;

	logic en; // One cycle per access
	logic we;
	fmap_pkg::unit_idx_t unit;
	fmap_pkg::pix_addr_t addr;
	fmap_pkg::pixel_t wdata;
	fmap_pkg::pixel_t rdata; // Valid the cycle after a read

	modport host (
		output en,
		output we,
		output unit,
		output addr,
		output wdata,
		input rdata
	);

	modport array (
		input en,
		input we,
		input unit,
		input addr,
		input wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* fmap_array/fmap_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fmap_settings.svh"

module fmap_bank (
	input wire clk,
	input wire a_en,
	input wire a_we,
	input wire fmap_pkg::pix_addr_t a_addr,
	input wire fmap_pkg::pixel_t a_wdata,
	output fmap_pkg::pixel_t a_rdata,
	input wire b_en,
	input wire fmap_pkg::pix_addr_t b_addr,
	output fmap_pkg::pixel_t b_rdata
);

	localparam int DEPTH = `FMAP_IFM_SIZE * `FMAP_IFM_SIZE;

	fmap_pkg::pixel_t mem [DEPTH];

	// Port A, write or registered read
	always_ff @(posedge clk)
	begin
		if (a_en)
		begin
			if (a_we)
				mem[a_addr] <= a_wdata;
			else
				a_rdata <= mem[a_addr];
		end
	end

	// Port B, read only, sees the old word on a collision
	always_ff @(posedge clk)
	begin
		if (b_en)
			b_rdata <= mem[b_addr];
	end

endmodule

`default_nettype wire

/* fmap_array/fmap_bank_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fmap_settings.svh"

module fmap_bank_array (
	input wire clk,
	input wire reset,
	fmap_access_if.array host,
	input wire fmap_pkg::group_t host_group,
	input wire next_en_a,
	input wire next_en_b,
	input wire fmap_pkg::pix_addr_t next_addr_a,
	input wire fmap_pkg::pix_addr_t next_addr_b,
	output fmap_pkg::pixel_t next_data_a [`FMAP_UNITS],
	output fmap_pkg::pixel_t next_data_b [`FMAP_UNITS]
);

	fmap_pkg::pixel_t a_rdata [`FMAP_GROUPS][`FMAP_UNITS];
	fmap_pkg::pixel_t b_rdata [`FMAP_GROUPS][`FMAP_UNITS];
	fmap_pkg::pixel_t hold_a [`FMAP_UNITS];

	fmap_pkg::group_t next_group;
	fmap_pkg::group_t rd_group_a;
	fmap_pkg::group_t rd_group_b;
	fmap_pkg::group_t host_rd_group;
	fmap_pkg::unit_idx_t host_rd_unit;
	logic rd_valid_a;

	assign next_group = ~host_group; // Next layer always reads the other group

	for (genvar g = 0; g < `FMAP_GROUPS; g++)
	begin : g_group
		for (genvar u = 0; u < `FMAP_UNITS; u++)
		begin : g_unit
			logic is_host;
			logic host_hit;

			assign is_host = (host_group == fmap_pkg::group_t'(g));
			assign host_hit = host.en && (host.unit == fmap_pkg::unit_idx_t'(u));

			fmap_bank bank (
				.clk(clk),
				.a_en(is_host ? host_hit : next_en_a),
				.a_we(is_host && host.we),
				.a_addr(is_host ? host.addr : next_addr_a),
				.a_wdata(host.wdata),
				.a_rdata(a_rdata[g][u]),
				.b_en(next_en_b && !is_host),
				.b_addr(next_addr_b),
				.b_rdata(b_rdata[g][u])
			);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_group_a <= '1; // Group 1 until CTRL is written
			rd_group_b <= '1;
			rd_valid_a <= 1'b0;
			host_rd_group <= '0;
			host_rd_unit <= '0;
		end
		else
		begin
			rd_valid_a <= next_en_a;
			if (next_en_a)
				rd_group_a <= next_group;
			if (next_en_b)
				rd_group_b <= next_group;
			if (host.en && !host.we)
			begin
				host_rd_group <= host_group;
				host_rd_unit <= host.unit;
			end
		end
	end

	// Port A may be taken over by the host after a flip, so keep a copy
	always_ff @(posedge clk)
	begin
		if (rd_valid_a)
			hold_a <= next_data_a;
	end

	always_comb
	begin
		for (int u = 0; u < `FMAP_UNITS; u++)
		begin
			next_data_a[u] = rd_valid_a ? a_rdata[rd_group_a][u] : hold_a[u];
			next_data_b[u] = b_rdata[rd_group_b][u];
		end
	end

	always_comb
	begin
		host.rdata = '0;
		if (host_rd_unit < `FMAP_UNITS)
			host.rdata = a_rdata[host_rd_group][host_rd_unit];
	end

endmodule

`default_nettype wire

/* design/apb_fmap_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fmap_settings.svh"

module apb_fmap_port (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`FMAP_APB_ADDR_W-1:0] paddr,
	input wire fmap_pkg::pixel_t pwdata,
	output fmap_pkg::pixel_t prdata,
	output logic pready,
	output logic pslverr,
	fmap_access_if.host host,
	output fmap_pkg::group_t host_group
);

	localparam int ADDR_LSB = 2; // Word aligned pixel index
	localparam int UNIT_LSB = 8;

	logic is_ctrl;
	logic bad_unit;
	logic first_cycle;
	logic rd_wait;
	fmap_pkg::group_t ctrl_q;
	fmap_pkg::unit_idx_t unit;

	assign is_ctrl = paddr[`FMAP_CTRL_BIT];
	assign unit = paddr[UNIT_LSB +: $bits(fmap_pkg::unit_idx_t)];
	assign bad_unit = !is_ctrl && (unit >= `FMAP_UNITS);

	// Access phase, excluding the wait cycle of a pixel read
	assign first_cycle = psel && penable && !rd_wait;

	assign host.en = first_cycle && !is_ctrl && !bad_unit;
	assign host.we = pwrite;
	assign host.unit = unit;
	assign host.addr = paddr[ADDR_LSB +: $bits(fmap_pkg::pix_addr_t)];
	assign host.wdata = pwdata;

	assign pready = psel && penable && (rd_wait || pwrite || is_ctrl || bad_unit);
	assign pslverr = first_cycle && bad_unit;

	always_comb
	begin
		if (rd_wait)
			prdata = host.rdata;
		else if (is_ctrl)
			prdata = fmap_pkg::pixel_t'(ctrl_q);
		else
			prdata = '0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_wait <= 1'b0;
			ctrl_q <= '0;
		end
		else
		begin
			rd_wait <= host.en && !pwrite; // One wait state per pixel read
			if (first_cycle && is_ctrl && pwrite)
				ctrl_q <= pwdata[0 +: $bits(fmap_pkg::group_t)];
		end
	end

	assign host_group = ctrl_q;

endmodule

`default_nettype wire

/* design/fmap_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fmap_settings.svh"

module fmap_buffer_top (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`FMAP_APB_ADDR_W-1:0] paddr,
	input wire [`FMAP_DATA_WIDTH-1:0] pwdata,
	output logic [`FMAP_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire next_en_a,
	input wire [`FMAP_ADDR_W-1:0] next_addr_a,
	input wire next_en_b,
	input wire [`FMAP_ADDR_W-1:0] next_addr_b,
	output logic [`FMAP_UNITS*`FMAP_DATA_WIDTH-1:0] next_data_a,
	output logic [`FMAP_UNITS*`FMAP_DATA_WIDTH-1:0] next_data_b
);

	fmap_access_if host_if ();

	fmap_pkg::group_t host_group;
	fmap_pkg::pixel_t data_a [`FMAP_UNITS];
	fmap_pkg::pixel_t data_b [`FMAP_UNITS];

	apb_fmap_port apb_port (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.host(host_if),
		.host_group(host_group)
	);

	fmap_bank_array bank_array (
		.clk(clk),
		.reset(reset),
		.host(host_if),
		.host_group(host_group),
		.next_en_a(next_en_a),
		.next_en_b(next_en_b),
		.next_addr_a(next_addr_a),
		.next_addr_b(next_addr_b),
		.next_data_a(data_a),
		.next_data_b(data_b)
	);

	// Unit u lands in slice u
	for (genvar u = 0; u < `FMAP_UNITS; u++)
	begin : g_pack
		assign next_data_a[u*`FMAP_DATA_WIDTH +: `FMAP_DATA_WIDTH] = data_a[u];
		assign next_data_b[u*`FMAP_DATA_WIDTH +: `FMAP_DATA_WIDTH] = data_b[u];
	end

endmodule

`default_nettype wire

/* bench/fmap_buffer_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fmap_buffer_assert (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pready,
	input wire pslverr,
	input wire host_en
);

	int fail_count = 0;

	// Pixel reads add one wait state, all else completes at once
	property pready_in_time;
		@(posedge clk) disable iff (reset)
		$rose(psel && penable) |-> ##[0:1] pready;
	endproperty

	property pslverr_with_pready;
		@(posedge clk) disable iff (reset)
		pslverr |-> pready;
	endproperty

	property access_in_phase;
		@(posedge clk) disable iff (reset)
		host_en |-> (psel && penable);
	endproperty

	a_pready_in_time: assert property (pready_in_time)
		else
		begin
			$error("pready missing two cycles after the access phase began");
			fail_count++;
		end
	a_pslverr_with_pready: assert property (pslverr_with_pready)
		else
		begin
			$error("pslverr high while pready is low");
			fail_count++;
		end
	a_access_in_phase: assert property (access_in_phase)
		else
		begin
			$error("bank access issued outside an APB access phase");
			fail_count++;
		end

endmodule

`default_nettype wire

/* bench/fmap_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fmap_settings.svh"

module fmap_buffer_tb;

	localparam int UNITS = `FMAP_UNITS;
	localparam int DW = `FMAP_DATA_WIDTH;
	localparam int TIMEOUT_CYCLES = 20000; // Whole run needs about 4000
	localparam logic [`FMAP_APB_ADDR_W-1:0] CTRL_ADDR = 1 << `FMAP_CTRL_BIT;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`FMAP_APB_ADDR_W-1:0] paddr;
	logic [DW-1:0] pwdata;
	logic [DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic next_en_a;
	logic [`FMAP_ADDR_W-1:0] next_addr_a;
	logic next_en_b;
	logic [`FMAP_ADDR_W-1:0] next_addr_b;
	logic [UNITS*DW-1:0] next_data_a;
	logic [UNITS*DW-1:0] next_data_b;

	logic [DW-1:0] model [2][UNITS][64]; // Group, unit, pixel
	logic cur_group; // Group owned by the host
	logic [31:0] rng_state;
	int error_count;
	int cycles;

	fmap_buffer_top UUT (.*);

	bind fmap_buffer_top fmap_buffer_assert checks (.clk(clk), .reset(reset), .psel(psel),
		.penable(penable), .pready(pready), .pslverr(pslverr), .host_en(host_if.en));

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [11:0] pix_paddr(input logic [1:0] unit, input logic [5:0] addr);
		return {2'b00, unit, addr, 2'b00};
	endfunction

	task automatic stop_run(input string msg);
		error_count++;
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic apb_transfer(input logic write, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err, output int waits);
		waits = 0;
		@(posedge clk);
		#1;
		psel = 1'b1;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
		begin
			waits++;
			@(negedge clk);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		logic bad;
		int waits;
		bad = !addr[`FMAP_CTRL_BIT] && (addr[9:8] == 2'd3);
		apb_transfer(1'b1, addr, data, rdata, err, waits);
		assert (waits == 0)
		else stop_run($sformatf("mismatch write wait states: got %h expected %h", waits, 0));
		assert (err === bad)
		else stop_run($sformatf("mismatch pslverr: got %h expected %h", err, bad));
		if (addr[`FMAP_CTRL_BIT])
			cur_group = data[0];
		else if (!bad)
			model[cur_group][addr[9:8]][addr[7:2]] = data;
	endtask

	task automatic apb_read(input logic [11:0] addr);
		logic [31:0] rdata;
		logic [31:0] exp;
		logic err;
		logic bad;
		int waits;
		int exp_waits;
		bad = !addr[`FMAP_CTRL_BIT] && (addr[9:8] == 2'd3);
		exp_waits = (addr[`FMAP_CTRL_BIT] || bad) ? 0 : 1;
		apb_transfer(1'b0, addr, '0, rdata, err, waits);
		assert (err === bad)
		else stop_run($sformatf("mismatch pslverr: got %h expected %h", err, bad));
		assert (waits == exp_waits)
		else stop_run($sformatf("mismatch read wait states: got %h expected %h", waits, exp_waits));
		if (!bad)
		begin
			exp = addr[`FMAP_CTRL_BIT] ? {31'b0, cur_group} : model[cur_group][addr[9:8]][addr[7:2]];
			assert (rdata === exp)
			else stop_run($sformatf("mismatch prdata at %h: got %h expected %h", addr, rdata, exp));
		end
	endtask

	task automatic check_next_data(input logic [DW-1:0] exp_a [UNITS],
		input logic [DW-1:0] exp_b [UNITS]);
		for (int u = 0; u < UNITS; u++)
		begin
			assert (next_data_a[u*DW +: DW] === exp_a[u])
			else stop_run($sformatf("mismatch next_data_a unit %0d: got %h expected %h",
				u, next_data_a[u*DW +: DW], exp_a[u]));
			assert (next_data_b[u*DW +: DW] === exp_b[u])
			else stop_run($sformatf("mismatch next_data_b unit %0d: got %h expected %h",
				u, next_data_b[u*DW +: DW], exp_b[u]));
		end
	endtask

	// New random address on both ports every cycle, data checked one cycle later
	task automatic next_read(input int count);
		logic [DW-1:0] exp_a [UNITS];
		logic [DW-1:0] exp_b [UNITS];
		logic [31:0] rnd;
		@(posedge clk);
		#1;
		for (int i = 0; i <= count; i++)
		begin
			if (i > 0)
				check_next_data(exp_a, exp_b);
			next_en_a = (i < count);
			next_en_b = (i < count);
			if (i < count)
			begin
				rnd = rand32();
				next_addr_a = rnd[5:0];
				next_addr_b = rnd[13:8];
				for (int u = 0; u < UNITS; u++)
				begin
					exp_a[u] = model[cur_group ^ 1'b1][u][rnd[5:0]];
					exp_b[u] = model[cur_group ^ 1'b1][u][rnd[13:8]];
				end
			end
			@(posedge clk);
			#1;
		end
		repeat (2) @(posedge clk); // Outputs hold while idle
		#1;
		check_next_data(exp_a, exp_b);
	endtask

	task automatic ctrl_reset_and_write();
		@(negedge clk);
		assert (!pready && !pslverr)
		else stop_run("pready or pslverr is high after reset");
		apb_read(CTRL_ADDR);
		apb_write(CTRL_ADDR, 32'h1);
		apb_read(CTRL_ADDR);
	endtask

	task automatic fill_and_read_back();
		for (int u = 0; u < UNITS; u++)
			for (int a = 0; a < 64; a++)
				apb_write(pix_paddr(u, a), rand32());
		for (int u = 0; u < UNITS; u++)
			for (int a = 0; a < 64; a++)
				apb_read(pix_paddr(u, a));
	endtask

	task automatic read_after_flip();
		apb_write(CTRL_ADDR, {31'b0, ~cur_group});
		next_read(200);
	endtask

	task automatic ping_pong_isolation();
		fork
			begin
				for (int u = 0; u < UNITS; u++)
					for (int a = 0; a < 64; a++)
						apb_write(pix_paddr(u, a), rand32());
			end
			next_read(200);
		join
	endtask

	task automatic bad_unit_rejected();
		for (int i = 0; i < 4; i++)
		begin
			apb_write(pix_paddr(2'd3, rand32()), rand32());
			apb_read(pix_paddr(2'd3, rand32()));
		end
		for (int u = 0; u < UNITS; u++)
			for (int a = 0; a < 64; a++)
				apb_read(pix_paddr(u, a));
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
			assert (UUT.checks.fail_count == 0)
			else stop_run("a bound protocol assertion failed");
		end
		$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

	initial
	begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		next_en_a = 1'b0;
		next_addr_a = '0;
		next_en_b = 1'b0;
		next_addr_b = '0;
		rng_state = 32'd89678;
		cur_group = 1'b0;
		error_count = 0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		ctrl_reset_and_write();
		fill_and_read_back();
		read_after_flip();
		ping_pong_isolation();
		bad_unit_rejected();
		if (error_count == 0 && UUT.checks.fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/fmap_pkg.sv
common/fmap_access_if.sv
fmap_array/fmap_bank.sv
fmap_array/fmap_bank_array.sv
design/apb_fmap_port.sv
design/fmap_buffer_top.sv
bench/fmap_buffer_assert.sv
bench/fmap_buffer_tb.sv
